/* logic/axi_fifo_rd.sv */
// axi read fifo with optional address reservation gate and r data buffer
module axi_fifo_rd
    import axi_pkg::*;
#(
    parameter int FIFO_DEPTH = 16,
    parameter bit FIFO_DELAY = 1'b1
) (
    input  logic    clk,
    input  logic    rst,

    input  axi_ar_t s_ar,
    input  logic    s_arvalid,
    output logic    s_arready,
    output axi_r_t  s_r,
    output logic    s_rvalid,
    input  logic    s_rready,

    output axi_ar_t m_ar,
    output logic    m_arvalid,
    input  logic    m_arready,
    input  axi_r_t  m_r,
    input  logic    m_rvalid,
    output logic    m_rready
);

    localparam int AW = $clog2(FIFO_DEPTH);

    if (FIFO_DELAY) begin : g_gate
        // wide enough for a 256 beat burst on a small fifo
        localparam int COUNT_W = ((AW > 8) ? AW : 8) + 1;

        typedef enum logic {
            GATE_IDLE,
            GATE_WAIT
        } gate_state_e;

        gate_state_e        state_reg;
        gate_state_e        state_next;
        logic [COUNT_W-1:0] count_reg;
        logic [COUNT_W-1:0] count_next;
        axi_ar_t            ar_reg;
        axi_ar_t            ar_next;
        logic               arvalid_reg;
        logic               arvalid_next;
        logic               arready_reg;
        logic               arready_next;

        // room for len+1 more beats, or nothing reserved at all
        function automatic logic burst_fits(input logic [COUNT_W-1:0] count,
                                            input logic [7:0] len);
            logic [COUNT_W:0] total;
            total = {1'b0, count} + len + 1'b1;
            return (count == '0) || (total <= (COUNT_W+1)'(FIFO_DEPTH));
        endfunction

        assign m_ar = ar_reg;
        assign m_arvalid = arvalid_reg;
        assign s_arready = arready_reg;

        always_comb begin
            state_next = state_reg;
            count_next = count_reg;
            ar_next = ar_reg;
            arvalid_next = arvalid_reg && !m_arready;
            arready_next = arready_reg;

            case (state_reg)
                GATE_IDLE: begin
                    arready_next = !m_arvalid || m_arready;
                    if (s_arvalid && s_arready) begin
                        arready_next = 1'b0;
                        ar_next = s_ar;
                        if (burst_fits(count_reg, s_ar.len)) begin
                            count_next = count_reg + COUNT_W'(s_ar.len) + 1'b1;
                            arvalid_next = 1'b1;
                        end else begin
                            state_next = GATE_WAIT;
                        end
                    end
                end
                GATE_WAIT: begin
                    arready_next = 1'b0;
                    if (burst_fits(count_reg, ar_reg.len)) begin
                        count_next = count_reg + COUNT_W'(ar_reg.len) + 1'b1;
                        arvalid_next = 1'b1;
                        state_next = GATE_IDLE;
                    end
                end
                default: begin
                    state_next = GATE_IDLE;
                end
            endcase

            // release one reserved slot per delivered beat
            if (s_rvalid && s_rready) begin
                count_next = count_next - 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            ar_reg <= ar_next;
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                state_reg <= GATE_IDLE;
                count_reg <= '0;
                arvalid_reg <= 1'b0;
                arready_reg <= 1'b0;
            end else begin
                state_reg <= state_next;
                count_reg <= count_next;
                arvalid_reg <= arvalid_next;
                arready_reg <= arready_next;
            end
        end

        // an oversized burst is only released with nothing else reserved
        assert property (@(posedge clk) disable iff (rst)
            $rose(count_reg > COUNT_W'(FIFO_DEPTH)) |-> $past(count_reg) == '0);

        // every beat leaving the data fifo was reserved by a forwarded burst
        assert property (@(posedge clk) disable iff (rst)
            s_rvalid && s_rready |-> count_reg != '0);
    end else begin : g_bypass
        assign m_ar = s_ar;
        assign m_arvalid = s_arvalid;
        assign s_arready = m_arready;
    end

    r_data_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_r_data_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_r      (m_r),
        .in_valid  (m_rvalid),
        .in_ready  (m_rready),
        .out_r     (s_r),
        .out_valid (s_rvalid),
        .out_ready (s_rready)
    );

endmodule

/* logic/axi_pkg.sv */
// axi read channel widths, burst and response types, ar and r channel structs
package axi_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 16;
    localparam int ID_W = 4;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    // read address channel, 33 bits
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        axi_burst_e        burst;
    } axi_ar_t;

    // read data channel, 39 bits
    // also the storage word of the data fifo
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        axi_resp_e         resp;
        logic              last;
    } axi_r_t;

endpackage

/* logic/axi_ram_rd.sv */
// preloadable ram with an axi burst read responder
module axi_ram_rd
    import axi_pkg::*;
    import mem_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  logic    clk,
    input  logic    rst,

    input  mem_wr_t mem_wr,

    input  axi_ar_t ar,
    input  logic    ar_valid,
    output logic    ar_ready,
    output axi_r_t  r,
    output logic    r_valid,
    input  logic    r_ready
);

    localparam int MEM_AW = $clog2(MEM_WORDS);

    logic [DATA_W-1:0] mem [MEM_WORDS];

    rd_state_e         state_reg;
    rd_state_e         state_next;
    axi_ar_t           cur_reg;
    axi_ar_t           cur_next;
    logic [7:0]        beat_reg;
    logic [7:0]        beat_next;
    logic              rvalid_reg;
    logic              rvalid_next;
    logic              load;
    logic [ADDR_W-1:0] word_next;
    logic              in_range;
    axi_r_t            r_reg;

    // preload, visible one cycle after the strobe
    always_ff @(posedge clk) begin
        if (mem_wr.en && (mem_wr.addr < MEM_WORDS)) begin
            mem[mem_wr.addr[MEM_AW-1:0]] <= mem_wr.data;
        end
    end

    assign ar_ready = (state_reg == RD_IDLE);
    assign r = r_reg;
    assign r_valid = rvalid_reg;

    always_comb begin
        state_next = state_reg;
        cur_next = cur_reg;
        beat_next = beat_reg;
        rvalid_next = rvalid_reg;
        load = 1'b0;

        case (state_reg)
            RD_IDLE: begin
                if (ar_valid) begin
                    cur_next = ar;
                    beat_next = '0;
                    rvalid_next = 1'b1;
                    load = 1'b1;
                    state_next = RD_BURST;
                end
            end
            RD_BURST: begin
                if (rvalid_reg && r_ready) begin
                    if (r_reg.last) begin
                        rvalid_next = 1'b0;
                        state_next = RD_IDLE;
                    end else begin
                        beat_next = beat_reg + 1'b1;
                        load = 1'b1;
                        // wrap is stepped like incr
                        if (cur_reg.burst != BURST_FIXED) begin
                            cur_next.addr = cur_reg.addr + (ADDR_W'(1) << cur_reg.size);
                        end
                    end
                end
            end
            default: begin
                state_next = RD_IDLE;
            end
        endcase
    end

    assign word_next = cur_next.addr >> 2;
    assign in_range = (word_next < MEM_WORDS);

    // synchronous ram read into the r register
    always_ff @(posedge clk) begin
        cur_reg <= cur_next;
        if (load) begin
            r_reg.id <= cur_next.id;
            r_reg.last <= (beat_next == cur_next.len);
            if (in_range) begin
                r_reg.data <= mem[word_next[MEM_AW-1:0]];
                r_reg.resp <= RESP_OKAY;
            end else begin
                r_reg.data <= '0;
                r_reg.resp <= RESP_SLVERR;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= RD_IDLE;
            beat_reg <= '0;
            rvalid_reg <= 1'b0;
        end else begin
            state_reg <= state_next;
            beat_reg <= beat_next;
            rvalid_reg <= rvalid_next;
        end
    end

    // a stalled beat holds its payload until accepted
    assert property (@(posedge clk) disable iff (rst)
        r_valid && !r_ready |=> r_valid && $stable(r));

endmodule

/* logic/mem_pkg.sv */
// ram preload port struct and read responder state type
package mem_pkg;

    localparam int MEM_ADDR_W = 16;
    localparam int MEM_DATA_W = 32;

    // one-cycle preload strobe, word addressed
    typedef struct packed {
        logic                  en;
        logic [MEM_ADDR_W-1:0] addr;
        logic [MEM_DATA_W-1:0] data;
    } mem_wr_t;

    typedef enum logic {
        RD_IDLE,
        RD_BURST
    } rd_state_e;

endpackage

/* logic/r_data_fifo.sv */
// ring buffer for axi r beats with registered memory read and output register
module r_data_fifo
    import axi_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic   clk,
    input  logic   rst,

    input  axi_r_t in_r,
    input  logic   in_valid,
    output logic   in_ready,

    output axi_r_t out_r,
    output logic   out_valid,
    input  logic   out_ready
);

    localparam int AW = $clog2(FIFO_DEPTH);

    // pointers carry one extra wrap bit
    logic [AW:0] wr_ptr_reg;
    logic [AW:0] wr_ptr_next;
    logic [AW:0] wr_addr_reg;
    logic [AW:0] rd_ptr_reg;
    logic [AW:0] rd_ptr_next;
    logic [AW:0] rd_addr_reg;

    axi_r_t mem [FIFO_DEPTH];
    axi_r_t mem_rd_reg;
    logic   mem_rd_valid_reg;
    logic   mem_rd_valid_next;

    axi_r_t out_reg;
    logic   out_valid_reg;
    logic   out_valid_next;

    logic full;
    logic empty;
    logic write;
    logic read;
    logic store_output;

    assign full = (wr_ptr_reg[AW] != rd_ptr_reg[AW]) &&
                  (wr_ptr_reg[AW-1:0] == rd_ptr_reg[AW-1:0]);
    assign empty = (wr_ptr_reg == rd_ptr_reg);

    assign in_ready = !full;
    assign out_r = out_reg;
    assign out_valid = out_valid_reg;

    // write side
    assign write = in_valid && !full;
    assign wr_ptr_next = write ? wr_ptr_reg + 1'b1 : wr_ptr_reg;

    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_addr_reg[AW-1:0]] <= in_r;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_reg <= '0;
            wr_addr_reg <= '0;
        end else begin
            wr_ptr_reg <= wr_ptr_next;
            wr_addr_reg <= wr_ptr_next;
        end
    end

    // read stage refills when empty or when the output register takes it
    assign store_output = out_ready || !out_valid_reg;
    assign read = !empty && (store_output || !mem_rd_valid_reg);
    assign rd_ptr_next = read ? rd_ptr_reg + 1'b1 : rd_ptr_reg;

    always_comb begin
        mem_rd_valid_next = mem_rd_valid_reg;
        if (store_output || !mem_rd_valid_reg) begin
            mem_rd_valid_next = !empty;
        end
    end

    always_ff @(posedge clk) begin
        if (read) begin
            mem_rd_reg <= mem[rd_addr_reg[AW-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr_reg <= '0;
            rd_addr_reg <= '0;
            mem_rd_valid_reg <= 1'b0;
        end else begin
            rd_ptr_reg <= rd_ptr_next;
            rd_addr_reg <= rd_ptr_next;
            mem_rd_valid_reg <= mem_rd_valid_next;
        end
    end

    // output register
    assign out_valid_next = store_output ? mem_rd_valid_reg : out_valid_reg;

    always_ff @(posedge clk) begin
        if (store_output) begin
            out_reg <= mem_rd_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg <= 1'b0;
        end else begin
            out_valid_reg <= out_valid_next;
        end
    end

    // occupancy stays within depth, so a full buffer is never overwritten
    assert property (@(posedge clk) disable iff (rst)
        (wr_ptr_reg - rd_ptr_reg) <= (AW+1)'(FIFO_DEPTH));

endmodule

/* logic/rd_fifo_subsys.sv */
// axi read fifo in front of a preloadable ram burst read responder
module rd_fifo_subsys
    import axi_pkg::*;
    import mem_pkg::*;
#(
    parameter int FIFO_DEPTH = 16,
    parameter bit FIFO_DELAY = 1'b1,
    parameter int MEM_WORDS  = 256
) (
    input  logic    clk,
    input  logic    rst,

    input  mem_wr_t mem_wr,

    input  axi_ar_t s_ar,
    input  logic    s_arvalid,
    output logic    s_arready,
    output axi_r_t  s_r,
    output logic    s_rvalid,
    input  logic    s_rready
);

    // fifo to responder
    axi_ar_t m_ar;
    logic    m_arvalid;
    logic    m_arready;
    axi_r_t  m_r;
    logic    m_rvalid;
    logic    m_rready;

    axi_fifo_rd #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .FIFO_DELAY (FIFO_DELAY)
    ) i_axi_fifo_rd (
        .clk       (clk),
        .rst       (rst),
        .s_ar      (s_ar),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_r       (s_r),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .m_ar      (m_ar),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .m_r       (m_r),
        .m_rvalid  (m_rvalid),
        .m_rready  (m_rready)
    );

    axi_ram_rd #(
        .MEM_WORDS (MEM_WORDS)
    ) i_axi_ram_rd (
        .clk      (clk),
        .rst      (rst),
        .mem_wr   (mem_wr),
        .ar       (m_ar),
        .ar_valid (m_arvalid),
        .ar_ready (m_arready),
        .r        (m_r),
        .r_valid  (m_rvalid),
        .r_ready  (m_rready)
    );

endmodule

/* project.f */
logic/axi_pkg.sv
logic/mem_pkg.sv
logic/r_data_fifo.sv
logic/axi_fifo_rd.sv
logic/axi_ram_rd.sv
logic/rd_fifo_subsys.sv
testbench/tb_rd_fifo_subsys.sv

/* testbench/tb_rd_fifo_subsys.sv */
// testbench for the axi read fifo subsystem with a reference ram model and directed tests
module tb_rd_fifo_subsys
    import axi_pkg::*;
    import mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FIFO_DEPTH = 16;
    localparam bit FIFO_DELAY = 1'b1;
    localparam int MEM_WORDS = 256;
    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 8;
    localparam logic [31:0] RANDOM_SEED = 32'h2f74ad4f;
    // 1 + 16 + 4 + 8 + 3*16 beats over all tests
    localparam int TOTAL_BEATS = 77;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20 + MEM_WORDS + RESET_CYCLES + 1000;

    logic    clk = 1'b0;
    logic    rst;
    mem_wr_t mem_wr;
    axi_ar_t s_ar;
    logic    s_arvalid;
    logic    s_arready;
    axi_r_t  s_r;
    logic    s_rvalid;
    logic    s_rready;

    logic [DATA_W-1:0] ref_mem [MEM_WORDS];
    axi_r_t            exp_q [$];
    axi_r_t            got_q [$];
    int                checks = 0;
    int                errors = 0;
    int                test_count = 0;

    rd_fifo_subsys #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .FIFO_DELAY (FIFO_DELAY),
        .MEM_WORDS  (MEM_WORDS)
    ) i_dut (
        .clk       (clk),
        .rst       (rst),
        .mem_wr    (mem_wr),
        .s_ar      (s_ar),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_r       (s_r),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // tasks below are entered and left on a falling edge

    task automatic preload_ram();
        for (int w = 0; w < MEM_WORDS; w++) begin
            ref_mem[w] = $urandom;
            mem_wr.en = 1'b1;
            mem_wr.addr = 16'(w);
            mem_wr.data = ref_mem[w];
            @(negedge clk);
        end
        mem_wr = '0;
    endtask

    // expected beats step 4 bytes per beat unless the burst is fixed
    task automatic expect_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                                input logic [7:0] len, input axi_burst_e burst);
        axi_r_t            beat;
        logic [ADDR_W-1:0] byte_addr;
        logic [ADDR_W-1:0] word;
        byte_addr = addr;
        for (int i = 0; i <= len; i++) begin
            word = byte_addr >> 2;
            beat.id = id;
            beat.last = (i == len);
            if (word < MEM_WORDS) begin
                beat.data = ref_mem[word];
                beat.resp = RESP_OKAY;
            end else begin
                beat.data = '0;
                beat.resp = RESP_SLVERR;
            end
            exp_q.push_back(beat);
            if (burst != BURST_FIXED) begin
                byte_addr = byte_addr + 16'd4;
            end
        end
    endtask

    task automatic send_ar(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                           input logic [7:0] len, input axi_burst_e burst);
        s_ar.id = id;
        s_ar.addr = addr;
        s_ar.len = len;
        s_ar.size = 3'd2;
        s_ar.burst = burst;
        s_arvalid = 1'b1;
        while (!s_arready) begin
            @(negedge clk);
        end
        @(negedge clk);
        s_arvalid = 1'b0;
    endtask

    // a beat seen here transfers on the next rising edge
    task automatic collect_beats(input int count, input bit random_stall);
        int taken;
        taken = 0;
        got_q.delete();
        while (taken < count) begin
            s_rready = random_stall ? 1'($urandom_range(0, 1)) : 1'b1;
            if (s_rvalid && s_rready) begin
                got_q.push_back(s_r);
                taken++;
            end
            @(negedge clk);
        end
        s_rready = 1'b0;
    endtask

    task automatic check_beat(input int idx, input axi_r_t got, input axi_r_t exp);
        checks++;
        if (got.id !== exp.id) begin
            $display("CHECK FAILED at %0t ns: s_r.id beat %0d expected %h actual %h",
                     $time, idx, exp.id, got.id);
            errors++;
        end
        checks++;
        if (got.data !== exp.data) begin
            $display("CHECK FAILED at %0t ns: s_r.data beat %0d expected %h actual %h",
                     $time, idx, exp.data, got.data);
            errors++;
        end
        checks++;
        if (got.resp !== exp.resp) begin
            $display("CHECK FAILED at %0t ns: s_r.resp beat %0d expected %h actual %h",
                     $time, idx, exp.resp, got.resp);
            errors++;
        end
        checks++;
        if (got.last !== exp.last) begin
            $display("CHECK FAILED at %0t ns: s_r.last beat %0d expected %b actual %b",
                     $time, idx, exp.last, got.last);
            errors++;
        end
    endtask

    task automatic compare_beats();
        checks++;
        if (got_q.size() != exp_q.size()) begin
            $display("CHECK FAILED at %0t ns: beat count expected %0d actual %0d",
                     $time, exp_q.size(), got_q.size());
            errors++;
        end
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            check_beat(i, got_q[i], exp_q[i]);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic run_burst_test(input string name, input logic [ID_W-1:0] id,
                                  input int word, input logic [7:0] len,
                                  input axi_burst_e burst, input bit random_stall);
        int errors_before;
        errors_before = errors;
        exp_q.delete();
        expect_burst(id, 16'(word * 4), len, burst);
        send_ar(id, 16'(word * 4), len, burst);
        collect_beats(int'(len) + 1, random_stall);
        compare_beats();
        report_test(name, errors_before);
    endtask

    // three bursts queue up behind a stalled master
    task automatic test_back_to_back();
        int errors_before;
        errors_before = errors;
        exp_q.delete();
        expect_burst(4'h1, 16'(64 * 4), 8'd15, BURST_INCR);
        expect_burst(4'h6, 16'(100 * 4), 8'd15, BURST_INCR);
        expect_burst(4'hc, 16'(200 * 4), 8'd15, BURST_INCR);
        fork
            begin
                send_ar(4'h1, 16'(64 * 4), 8'd15, BURST_INCR);
                send_ar(4'h6, 16'(100 * 4), 8'd15, BURST_INCR);
                send_ar(4'hc, 16'(200 * 4), 8'd15, BURST_INCR);
            end
            begin
                s_rready = 1'b0;
                repeat (100) @(negedge clk);
                checks++;
                if (!s_rvalid) begin
                    $display("no read beat was waiting at the output after the stall");
                    errors++;
                end
                collect_beats(48, 1'b0);
            end
        join
        compare_beats();
        report_test("back to back bursts", errors_before);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(RANDOM_SEED));
        rst = 1'b1;
        mem_wr = '0;
        s_ar = '0;
        s_arvalid = 1'b0;
        s_rready = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        checks++;
        if (s_arready !== 1'b0 || s_rvalid !== 1'b0) begin
            $display("handshake outputs were not low during reset");
            errors++;
        end
        rst = 1'b0;
        preload_ram();

        run_burst_test("single incr beat", 4'h3, 5, 8'd0, BURST_INCR, 1'b0);
        run_burst_test("incr burst with stalls", 4'h5, 32, 8'd15, BURST_INCR, 1'b1);
        run_burst_test("fixed burst", 4'h9, 10, 8'd3, BURST_FIXED, 1'b0);
        run_burst_test("burst across ram end", 4'h2, MEM_WORDS - 4, 8'd7, BURST_INCR, 1'b0);
        test_back_to_back();

        $display("tests %0d, checks %0d, errors %0d", test_count, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
